/* cross_domain_arbiter.f */
rtl/arb_pkg.sv
rtl/req_sync.sv
rtl/arb_core.sv
rtl/cross_domain_arbiter.sv
sim/arb_sva.sv
sim/arb_checker.sv
sim/tb_cross_domain_arbiter.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_cross_domain_arbiter
FILELIST  := cross_domain_arbiter.f
OBJDIR    := obj_dir
LOG       := sim.log
FAIL_MSG  := Result: FAILED
PASS_MSG  := Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

/* sim/tb_cross_domain_arbiter.sv */
// ==============================
// Testbench for the two-group arbiter driven by LFSR random requests
// ==============================

`timescale 1ns/1ns

module tb_cross_domain_arbiter
    import arb_pkg::*;
();

    localparam logic [15:0] SEED         = 16'd76;
    localparam int          CLK_HALF     = 4;
    // Alternating 5 and 6 ns halves average 5.5 ns
    localparam int          SRC_HALF_LO  = 5;
    localparam int          SRC_HALF_HI  = 6;
    localparam int          RESET_CYCLES = 10;
    localparam int          N_VEC        = 24;
    localparam int          N_ROUND      = 6;
    // Source clock periods each request pattern is held
    localparam int          HOLD_SRC     = 8;
    localparam int          TOTAL_VEC    = 4 * N_VEC + N_ROUND * (N_TOTAL + 1);
    localparam int          CYCLE_LIMIT  = TOTAL_VEC * 12 + 200;

    logic             clk;
    logic             src_clk;
    logic             rst;
    logic [N_REQ-1:0] req_a;
    logic [N_REQ-1:0] req_b;
    logic [N_REQ-1:0] grant;
    logic             grant_src;

    logic [15:0]      lfsr_state;
    int               cycle_count = 0;
    int               errors;
    int               checks;
    int               prev_errors;
    int               tests_run;
    int               sva_fails;

    cross_domain_arbiter cross_domain_arbiter_i (
        .clk       (clk),
        .rst       (rst),
        .req_a     (req_a),
        .req_b     (req_b),
        .grant     (grant),
        .grant_src (grant_src)
    );

    arb_checker check_i (
        .clk       (clk),
        .rst       (rst),
        .req_a     (req_a),
        .req_b     (req_b),
        .grant     (grant),
        .grant_src (grant_src),
        .errors    (errors),
        .checks    (checks)
    );

    bind cross_domain_arbiter arb_sva sva_i (
        .clk       (clk),
        .rst       (rst),
        .grant     (grant),
        .grant_src (grant_src)
    );

    always #CLK_HALF clk = ~clk;

    always begin
        #SRC_HALF_LO src_clk = 1'b1;
        #SRC_HALF_HI src_clk = 1'b0;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run stopped by timeout after %0d clk cycles", cycle_count);
            $display("Result: FAILED");
            $finish;
        end
    end

    // Galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(output logic [N_REQ-1:0] v);
        for (int i = 0; i < N_REQ; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v[i]       = lfsr_state[0];
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        $display("Test %-9s done, %0d errors", name, errors - prev_errors);
        prev_errors = errors;
    endtask

    // req_b changes on the source clock and req_a on the next clk falling edge
    task automatic apply_req(input logic [N_REQ-1:0] a, input logic [N_REQ-1:0] b);
        @(negedge src_clk);
        // Source edge may land on a clk rising edge
        req_b <= b;
        @(negedge clk);
        req_a = a;
        repeat (HOLD_SRC) @(negedge src_clk);
    endtask

    task automatic release_reset();
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        repeat (LAT_B + 4) @(negedge clk);
        report_test("reset");
    endtask

    task automatic run_group_a();
        logic [N_REQ-1:0] v;
        for (int n = 0; n < N_VEC; n++) begin
            @(negedge clk);
            take_bits(v);
            req_a = v;
        end
        @(negedge clk);
        req_a = '0;
        repeat (LAT_A + 2) @(negedge clk);
        report_test("group_a");
    endtask

    task automatic hold_group_b();
        logic [N_REQ-1:0] v;
        for (int n = 0; n < N_VEC; n++) begin
            take_bits(v);
            apply_req('0, v);
        end
        apply_req('0, '0);
        report_test("group_b");
    endtask

    task automatic contend_groups();
        logic [N_REQ-1:0] a;
        logic [N_REQ-1:0] b;
        for (int n = 0; n < N_VEC; n++) begin
            take_bits(a);
            take_bits(b);
            if (a == '0) begin
                a[0] = 1'b1;
            end
            if (b == '0) begin
                b[0] = 1'b1;
            end
            apply_req(a, b);
        end
        apply_req('0, '0);
        report_test("priority");
    endtask

    // Drop the winning line each step until nothing is left
    task automatic drop_winners();
        logic [N_REQ-1:0]   a;
        logic [N_REQ-1:0]   b;
        logic [N_TOTAL-1:0] all_req;
        for (int n = 0; n < N_ROUND; n++) begin
            take_bits(a);
            take_bits(b);
            all_req = {b, a};
            if (all_req == '0) begin
                all_req[0] = 1'b1;
            end
            while (all_req != '0) begin
                apply_req(all_req[N_REQ-1:0], all_req[N_TOTAL-1:N_REQ]);
                all_req = all_req & ~(all_req & (-all_req));
            end
            apply_req('0, '0);
        end
        report_test("release");
    endtask

    initial begin
        clk         = 1'b0;
        src_clk     = 1'b0;
        rst         = 1'b0;
        req_a       = '0;
        req_b       = '0;
        lfsr_state  = SEED;
        prev_errors = 0;
        tests_run   = 0;
        sva_fails   = 0;
        // Reset edge after time 0
        #1 rst = 1'b1;
        release_reset();
        run_group_a();
        hold_group_b();
        contend_groups();
        drop_winners();
        sva_fails = cross_domain_arbiter_i.sva_i.fail_count;
        $display("Tests: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
                 tests_run, checks, errors, sva_fails);
        if (errors == 0 && sva_fails == 0 && checks > 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* sim/arb_checker.sv */
// ==============================
// Reference model of the arbiter that compares the DUT grant on every clk edge
// ==============================

`timescale 1ns/1ns

module arb_checker
    import arb_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic [N_REQ-1:0] req_a,
    input  logic [N_REQ-1:0] req_b,
    input  logic [N_REQ-1:0] grant,
    input  logic             grant_src,
    output int               errors,
    output int               checks
);

    // req_a sampled on the last LAT_A edges with index 0 newest
    logic [N_REQ-1:0] a_hist [LAT_A];
    logic [N_REQ-1:0] a_old;

    // Last req_b value and how many edges it has held
    logic [N_REQ-1:0] b_last;
    int               b_stable;

    logic [N_REQ-1:0] exp_grant;
    logic             exp_src;
    logic             do_check;

    // Two's complement trick isolates the lowest set bit
    function automatic logic [N_REQ-1:0] lowest_set(input logic [N_REQ-1:0] v);
        return v & (-v);
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    initial begin
        errors = 0;
        checks = 0;
    end

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < LAT_A; i++) begin
                a_hist[i] = '0;
            end
            // Cleared synchronizers look like a long run of zero requests
            b_last   = '0;
            b_stable = LAT_B + 2;
            compare_value("grant", 32'(grant), 32'(0));
            compare_value("grant_src", 32'(grant_src), 32'(0));
        end else begin
            a_old    = a_hist[LAT_A-1];
            do_check = 1'b1;
            exp_src  = 1'b0;
            if (a_old != '0) begin
                // Group A outranks anything in group B
                exp_grant = lowest_set(a_old);
            end else if (b_stable >= LAT_B + 2) begin
                exp_grant = lowest_set(b_last);
                exp_src   = (b_last != '0);
            end else begin
                // Group B still crossing so the result is not yet defined
                do_check  = 1'b0;
                exp_grant = '0;
            end
            if (do_check) begin
                compare_value("grant", 32'(grant), 32'(exp_grant));
                compare_value("grant_src", 32'(grant_src), 32'(exp_src));
            end
            for (int i = LAT_A - 1; i > 0; i--) begin
                a_hist[i] = a_hist[i-1];
            end
            a_hist[0] = req_a;
            if (req_b == b_last) begin
                b_stable++;
            end else begin
                b_last   = req_b;
                b_stable = 1;
            end
        end
    end

endmodule

/* sim/arb_sva.sv */
// ==============================
// Grant assertions bound to the arbiter top level
// ==============================

`timescale 1ns/1ns

module arb_sva
    import arb_pkg::*;
(
    input logic             clk,
    input logic             rst,
    input logic [N_REQ-1:0] grant,
    input logic             grant_src
);

    // Failed assertions, read by the testbench top
    int fail_count = 0;

    // At most one line granted across both groups
    grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
        else begin
            $error("grant has more than one bit set");
            fail_count++;
        end

    // No source flag without a grant
    grant_src_idle: assert property (@(posedge clk) disable iff (rst)
        (grant == '0) |-> !grant_src)
        else begin
            $error("grant_src is high while grant is zero");
            fail_count++;
        end

    grant_reset: assert property (@(posedge clk) rst |-> (grant == '0 && !grant_src))
        else begin
            $error("grant or grant_src not zero while rst is high");
            fail_count++;
        end

endmodule

/* rtl/cross_domain_arbiter.sv */
// ==============================
// Two-group request arbiter, group A local, group B from another clock
// Group A outranks group B, grant_src tells which group won
// ==============================

`timescale 1ns/1ns

module cross_domain_arbiter
    import arb_pkg::*;
(
    input  logic             clk,
    input  logic             rst,

    // Group A, driven in the clk domain
    input  logic [N_REQ-1:0] req_a,

    // Group B, asynchronous to clk
    // each bit must hold for three clk periods to be seen
    input  logic [N_REQ-1:0] req_b,

    // Merged grant of both groups
    output logic [N_REQ-1:0] grant,

    // High when the grant belongs to group B
    output logic             grant_src
);

    // Requests after their synchronizers
    logic [N_REQ-1:0]   sync_a;
    logic [N_REQ-1:0]   sync_b;

    // Combined request and grant seen by the core
    logic [N_TOTAL-1:0] req_all;
    logic [N_TOTAL-1:0] core_grant;

    // Halves of the core grant
    logic [N_REQ-1:0]   grant_lo;
    logic [N_REQ-1:0]   grant_hi;

    // Values loaded into the output register
    logic [N_REQ-1:0]   grant_d;
    logic               grant_src_d;

    // Same-domain input register for group A
    req_sync #(
        .WIDTH  (N_REQ),
        .STAGES (SYNC_A_STAGES)
    ) sync_a_i (
        .clk  (clk),
        .rst  (rst),
        .din  (req_a),
        .dout (sync_a)
    );

    // Two flop synchronizer for group B, clocked on the destination clock
    req_sync #(
        .WIDTH  (N_REQ),
        .STAGES (SYNC_B_STAGES)
    ) sync_b_i (
        .clk  (clk),
        .rst  (rst),
        .din  (req_b),
        .dout (sync_b)
    );

    // Group A in the low half so it wins the priority scan
    assign req_all = {sync_b, sync_a};

    arb_core core (
        .clk   (clk),
        .rst   (rst),
        .req   (req_all),
        .grant (core_grant)
    );

    assign grant_lo = core_grant[N_REQ-1:0];
    assign grant_hi = core_grant[N_TOTAL-1:N_REQ];

    // The core grant is one-hot, so at most one half is set
    // and the OR keeps the merged vector one-hot too
    assign grant_d     = grant_lo | grant_hi;
    assign grant_src_d = |grant_hi;

    // Output register, grant and its source flag move together
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            grant     <= '0;
            grant_src <= 1'b0;
        end else begin
            grant     <= grant_d;
            grant_src <= grant_src_d;
        end
    end

endmodule

/* rtl/arb_core.sv */
// ==============================
// Registered fixed-priority arbiter, lowest set index wins
// Grant is one-hot or zero and lags the request by one clk
// ==============================

`timescale 1ns/1ns

module arb_core
    import arb_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic [N_TOTAL-1:0] req,
    output logic [N_TOTAL-1:0] grant
);

    // Next grant, computed from the current request
    logic [N_TOTAL-1:0] grant_d;

    // Set once a line has been picked in the scan
    logic               found;

    // Scan from index 0 upward
    // The first active line takes the grant, all others are masked
    always_comb begin
        grant_d = '0;
        found   = 1'b0;
        for (int i = 0; i < N_TOTAL; i++) begin
            if (req[i] && !found) begin
                grant_d[i] = 1'b1;
                found      = 1'b1;
            end
        end
    end

    // Re-arbitrated every cycle
    // A higher priority request takes over on the next edge,
    // and a dropped request releases its grant on the next edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            grant <= '0;
        end else begin
            grant <= grant_d;
        end
    end

endmodule

/* rtl/req_sync.sv */
// ==============================
// Register chain that brings a request vector into the clk domain
// Two or more stages for async inputs, one stage for local inputs
// ==============================

`timescale 1ns/1ns

module req_sync #(
    parameter int WIDTH  = 1,
    parameter int STAGES = 2
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout
);

    // Stage 0 samples din, the last stage drives dout
    logic [WIDTH-1:0] stage_q [STAGES];

    // The first stage may go metastable on an async input
    // and later stages give it a full period to resolve
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < STAGES; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= din;
            for (int i = 1; i < STAGES; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    // Delayed by exactly STAGES clk edges
    assign dout = stage_q[STAGES-1];

endmodule

/* rtl/arb_pkg.sv */
// ==============================
// Shared sizes and latencies for the two-group request arbiter
// Imported by the RTL, the testbench and the checker
// ==============================

package arb_pkg;

    // Request lines per group
    localparam int N_REQ = 2;

    // Group A occupies the low half, group B the high half
    localparam int N_TOTAL = 2 * N_REQ;

    // Group A is already in the clk domain
    // so a single input register is enough
    localparam int SYNC_A_STAGES = 1;

    // Group B arrives from an unrelated clock
    // and needs a two flop synchronizer
    localparam int SYNC_B_STAGES = 2;

    // Request to grant latency in clk edges
    // Sync stages, then the core register, then the output register
    localparam int LAT_A = SYNC_A_STAGES + 2;

    // Counted from the first clk edge that samples req_b
    localparam int LAT_B = SYNC_B_STAGES + 2;

endpackage
